// ==== compile.f ====
+incdir+.
fir_pkg.sv
fir_ctrl_fsm.sv
fir_cfg_regs.sv
fir_tap_counter.sv
fir_sample_buffer.sv
fir_mac.sv
fir_top.sv
tb_fir.sv

// ==== tb_fir.sv ====
`timescale 1ns/10ps
`include "fir_consts.svh"

module tb_fir;
    import fir_pkg::*;

    localparam int NRUNS  = 3;
    localparam int MAXLEN = 40;

    logic axis_clk, axis_rst_n;
    logic awvalid, awready, wvalid, wready, arvalid, arready, rvalid, rready;
    logic ss_tvalid, ss_tready, sm_tvalid, sm_tready, sm_tlast;
    fir_addr_t awaddr, araddr;
    fir_data_t wdata, rdata, ss_tdata, sm_tdata;

    // run table: stimulus plus model results
    int unsigned tbl_taps [NRUNS];
    int unsigned tbl_len  [NRUNS];
    fir_data_t   tbl_coef [NRUNS][`FIR_MAX_TAPS];
    fir_data_t   tbl_in   [NRUNS][MAXLEN];
    fir_data_t   tbl_exp  [NRUNS][MAXLEN];

    fir_top dut_i (.*);

    initial begin
        axis_clk = 1'b0;
        forever #50 axis_clk = ~axis_clk;
    end

    ////////////////////
    // failure reporting

    task automatic stop_run();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic report_timeout(string what);
        $display("timeout while waiting for %s at %0t ns", what, $time);
        stop_run();
    endtask

    task automatic check_data(string what, fir_data_t got, fir_data_t exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_ctrl(string what, ap_ctrl_t got, ap_ctrl_t exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(string what, logic got, logic exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            stop_run();
        end
    endtask

    ////////////////////
    // register port

    task automatic reg_write(fir_addr_t addr, fir_data_t data);
        int waited;
        waited  = 0;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        while (!(awready && wready)) begin
            @(negedge axis_clk);
            waited++;
            if (waited > 20) report_timeout("awready and wready");
        end
        @(negedge axis_clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        // both valids low for a cycle before the next write
        @(negedge axis_clk);
    endtask

    task automatic reg_read(fir_addr_t addr, output fir_data_t data);
        int waited;
        waited  = 0;
        araddr  = addr;
        arvalid = 1'b1;
        while (!arready) begin
            @(negedge axis_clk);
            waited++;
            if (waited > 20) report_timeout("arready");
        end
        @(negedge axis_clk);
        arvalid = 1'b0;
        rready  = 1'b1;
        waited  = 0;
        while (!rvalid) begin
            @(negedge axis_clk);
            waited++;
            if (waited > 20) report_timeout("rvalid");
        end
        data = rdata;
        @(negedge axis_clk);
        rready = 1'b0;
    endtask

    // clear takes 32 cycles, so several polls come back not idle
    task automatic wait_idle();
        fir_data_t rd;
        int        tries;
        tries = 0;
        reg_read(`FIR_ADDR_AP_CTRL, rd);
        while (!rd[2]) begin
            check_ctrl("ap_ctrl during clear", ap_ctrl_t'(rd), 3'b000);
            tries++;
            if (tries > 50) report_timeout("ap_ctrl idle");
            reg_read(`FIR_ADDR_AP_CTRL, rd);
        end
        check_ctrl("ap_ctrl when idle", ap_ctrl_t'(rd), 3'b100);
    endtask

    ////////////////////
    // streams

    task automatic send_sample(fir_data_t d);
        int gap;
        int waited;
        gap    = $urandom % 3;
        waited = 0;
        repeat (gap) @(negedge axis_clk);
        ss_tdata  = d;
        ss_tvalid = 1'b1;
        while (!ss_tready) begin
            @(negedge axis_clk);
            waited++;
            if (waited > 50) report_timeout("ss_tready");
        end
        @(negedge axis_clk);
        ss_tvalid = 1'b0;
    endtask

    // random back-pressure, result must not move while held
    task automatic take_result(output fir_data_t data, output logic last);
        int        waited;
        logic      taken;
        logic      seen;
        fir_data_t held;
        waited = 0;
        taken  = 1'b0;
        seen   = 1'b0;
        while (!taken) begin
            sm_tready = ($urandom % 4) != 0;
            if (sm_tvalid && seen) check_data("held sm_tdata", sm_tdata, held);
            if (sm_tvalid) begin
                seen = 1'b1;
                held = sm_tdata;
            end
            if (sm_tvalid && sm_tready) begin
                taken = 1'b1;
            end else begin
                @(negedge axis_clk);
                waited++;
                if (waited > 100) report_timeout("sm_tvalid");
            end
        end
        data = sm_tdata;
        last = sm_tlast;
        @(negedge axis_clk);
        sm_tready = 1'b0;
    endtask

    ////////////////////
    // table and model

    // sum of coef[i] * x[n-i], zero before the first sample, 32-bit wrap
    function automatic fir_data_t model_out(int r, int n);
        fir_data_t acc;
        acc = '0;
        for (int i = 0; i < int'(tbl_taps[r]); i++) begin
            if (n - i >= 0) acc = acc + tbl_coef[r][i] * tbl_in[r][n-i];
        end
        return acc;
    endfunction

    task automatic fill_table();
        fir_data_t base_coef [11];
        base_coef = '{0, -10, -9, 23, 56, 63, 56, 23, -9, -10, 0};
        tbl_taps = '{11, 32, 3};
        tbl_len  = '{12, 40, 5};
        for (int i = 0; i < 11; i++) tbl_coef[0][i] = base_coef[i];
        for (int n = 0; n < 12; n++) tbl_in[0][n] = fir_data_t'(n + 1);
        // run 1 wraps the sample buffer
        for (int i = 0; i < 32; i++) tbl_coef[1][i] = $urandom;
        for (int n = 0; n < 40; n++) tbl_in[1][n] = $urandom;
        for (int i = 0; i < 3; i++) tbl_coef[2][i] = fir_data_t'(i + 2);
        for (int n = 0; n < 5; n++) tbl_in[2][n] = fir_data_t'(7 * n - 20);
        for (int r = 0; r < NRUNS; r++) begin
            for (int n = 0; n < int'(tbl_len[r]); n++) tbl_exp[r][n] = model_out(r, n);
        end
    endtask

    initial begin
        fir_data_t rd;
        fir_data_t got;
        logic      last;
        void'($urandom(88));
        axis_rst_n = 1'b0;
        {awvalid, wvalid, arvalid, rready, ss_tvalid, sm_tready} = '0;
        awaddr   = '0;
        araddr   = '0;
        wdata    = '0;
        ss_tdata = '0;
        fill_table();
        repeat (3) @(posedge axis_clk);
        @(negedge axis_clk);
        // handshake outputs quiet in reset
        check_flag("awready in reset", awready, 1'b0);
        check_flag("wready in reset", wready, 1'b0);
        check_flag("arready in reset", arready, 1'b0);
        check_flag("rvalid in reset", rvalid, 1'b0);
        check_flag("ss_tready in reset", ss_tready, 1'b0);
        check_flag("sm_tvalid in reset", sm_tvalid, 1'b0);
        check_flag("sm_tlast in reset", sm_tlast, 1'b0);
        axis_rst_n = 1'b1;

        for (int r = 0; r < NRUNS; r++) begin
            wait_idle();
            reg_write(`FIR_ADDR_TAP_NUM, fir_data_t'(tbl_taps[r]));
            reg_write(`FIR_ADDR_DATA_LEN, fir_data_t'(tbl_len[r]));
            for (int i = 0; i < int'(tbl_taps[r]); i++) begin
                reg_write(fir_addr_t'(`FIR_ADDR_COEF_BASE + 4 * i), tbl_coef[r][i]);
            end
            for (int i = 0; i < int'(tbl_taps[r]); i++) begin
                reg_read(fir_addr_t'(`FIR_ADDR_COEF_BASE + 4 * i), rd);
                check_data("coefficient readback", rd, tbl_coef[r][i]);
            end
            reg_write(`FIR_ADDR_AP_CTRL, 32'h1);
            // busy now, so this write is dropped
            reg_write(`FIR_ADDR_COEF_BASE, ~tbl_coef[r][0]);
            for (int n = 0; n < int'(tbl_len[r]); n++) begin
                send_sample(tbl_in[r][n]);
                take_result(got, last);
                check_data("sm_tdata", got, tbl_exp[r][n]);
                check_flag("sm_tlast", last, n == int'(tbl_len[r]) - 1);
            end
            reg_read(`FIR_ADDR_AP_CTRL, rd);
            check_ctrl("ap_ctrl after last result", ap_ctrl_t'(rd), 3'b010);
            reg_read(`FIR_ADDR_COEF_BASE, rd);
            check_data("coefficient 0 after busy write", rd, tbl_coef[r][0]);
        end
        wait_idle();
        $display("sim passed");
        $finish;
    end

endmodule

// ==== fir_top.sv ====
`timescale 1ns/10ps

module fir_top (
    input  logic               axis_clk,
    input  logic               axis_rst_n,
    input  logic               awvalid,
    output logic               awready,
    input  fir_pkg::fir_addr_t awaddr,
    input  logic               wvalid,
    output logic               wready,
    input  fir_pkg::fir_data_t wdata,
    input  logic               arvalid,
    output logic               arready,
    input  fir_pkg::fir_addr_t araddr,
    output logic               rvalid,
    input  logic               rready,
    output fir_pkg::fir_data_t rdata,
    input  logic               ss_tvalid,
    input  fir_pkg::fir_data_t ss_tdata,
    output logic               ss_tready,
    output logic               sm_tvalid,
    output fir_pkg::fir_data_t sm_tdata,
    input  logic               sm_tready,
    output logic               sm_tlast
);
    import fir_pkg::*;

    fir_state_t state;
    ap_ctrl_t   ap_ctrl;
    fir_len_t   data_len;
    fir_len_t   tap_num;
    fir_data_t  coef;
    fir_data_t  x_out;
    fir_ptr_t   idx;
    logic       start;
    logic       ctrl_read;
    logic       clear_done;
    logic       run_done;
    logic       tap_issue;
    logic       sample_accept;

    fir_ctrl_fsm u_ctrl (
        .axis_clk, .axis_rst_n, .start, .clear_done, .run_done, .ctrl_read,
        .data_len, .ss_tvalid, .sm_tready, .state, .ap_ctrl, .ss_tready,
        .sm_tvalid, .sm_tlast, .sample_accept
    );

    fir_cfg_regs u_regs (
        .axis_clk, .axis_rst_n, .awvalid, .awaddr, .wvalid, .wdata, .arvalid,
        .araddr, .rready, .ap_ctrl, .coef_idx(idx), .awready, .wready, .arready,
        .rvalid, .rdata, .data_len, .tap_num, .coef, .start, .ctrl_read
    );

    fir_tap_counter u_taps (
        .axis_clk, .axis_rst_n, .state, .tap_num, .idx, .tap_issue,
        .clear_done, .run_done
    );

    fir_sample_buffer u_samples (
        .axis_clk, .axis_rst_n, .state, .idx, .sample_accept, .ss_tdata, .x_out
    );

    fir_mac u_mac (
        .axis_clk, .axis_rst_n, .tap_issue, .sample_accept, .coef, .x_out, .sm_tdata
    );

endmodule

// ==== fir_mac.sv ====
`timescale 1ns/10ps
`include "fir_consts.svh"

module fir_mac (
    input  logic               axis_clk,
    input  logic               axis_rst_n,
    input  logic               tap_issue,
    input  logic               sample_accept,
    input  fir_pkg::fir_data_t coef,
    input  fir_pkg::fir_data_t x_out,
    output fir_pkg::fir_data_t sm_tdata
);
    import fir_pkg::*;

    fir_data_t                coef_q;
    fir_data_t                x_q;
    logic                     op_vld;
    logic [2*`FIR_DATA_W-1:0] prod_full;
    fir_data_t                prod_q;
    logic                     prod_vld;
    fir_data_t                acc;

    assign prod_full = coef_q * x_q;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            op_vld   <= 1'b0;
            prod_vld <= 1'b0;
            acc      <= '0;
        end else begin
            op_vld   <= tap_issue;
            prod_vld <= op_vld;
            // new sample restarts the sum, then it holds through output
            if (sample_accept) begin
                acc <= '0;
            end else if (prod_vld) begin
                acc <= acc + prod_q;
            end
        end
    end

    ////////////////////
    // operand and product stages

    always_ff @(posedge axis_clk) begin
        if (tap_issue) begin
            coef_q <= coef;
            x_q    <= x_out;
        end
        if (op_vld) begin
            prod_q <= prod_full[`FIR_DATA_W-1:0];
        end
    end

    assign sm_tdata = acc;

endmodule

// ==== fir_sample_buffer.sv ====
`timescale 1ns/10ps
`include "fir_consts.svh"

module fir_sample_buffer (
    input  logic                axis_clk,
    input  logic                axis_rst_n,
    input  fir_pkg::fir_state_t state,
    input  fir_pkg::fir_ptr_t   idx,
    input  logic                sample_accept,
    input  fir_pkg::fir_data_t  ss_tdata,
    output fir_pkg::fir_data_t  x_out
);
    import fir_pkg::*;

    fir_data_t mem [`FIR_MAX_TAPS];
    fir_ptr_t  wr_ptr;
    fir_ptr_t  newest;
    fir_ptr_t  rd_ptr;

    // pointer arithmetic wraps at 32 on its own
    assign newest = wr_ptr - fir_ptr_t'(1);
    assign rd_ptr = newest - idx;
    assign x_out  = mem[rd_ptr];

    ////////////////////
    // write side

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            wr_ptr <= '0;
        end else if (state == st_clear) begin
            wr_ptr <= '0;
        end else if (sample_accept) begin
            wr_ptr <= wr_ptr + fir_ptr_t'(1);
        end
    end

    // zero history before each run
    always_ff @(posedge axis_clk) begin
        if (state == st_clear) begin
            mem[idx] <= '0;
        end else if (sample_accept) begin
            mem[wr_ptr] <= ss_tdata;
        end
    end

endmodule

// ==== fir_tap_counter.sv ====
`timescale 1ns/10ps
`include "fir_consts.svh"

module fir_tap_counter (
    input  logic                axis_clk,
    input  logic                axis_rst_n,
    input  fir_pkg::fir_state_t state,
    input  fir_pkg::fir_len_t   tap_num,
    output fir_pkg::fir_ptr_t   idx,
    output logic                tap_issue,
    output logic                clear_done,
    output logic                run_done
);
    import fir_pkg::*;

    // one extra bit so the count covers taps plus the drain
    localparam int CNT_W = `FIR_PTR_W + 1;

    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] taps;
    logic [CNT_W-1:0] last_cyc;

    assign taps     = tap_num[CNT_W-1:0];
    assign last_cyc = taps + CNT_W'(`FIR_MAC_LAT - 1);

    assign tap_issue  = (state == st_compute) && (cnt < taps);
    assign clear_done = (state == st_clear) && (cnt == CNT_W'(`FIR_MAX_TAPS - 1));
    assign run_done   = (state == st_compute) && (cnt == last_cyc);

    // address during clear, tap index while issuing
    assign idx = (state == st_clear || tap_issue) ? cnt[`FIR_PTR_W-1:0] : '0;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            cnt <= '0;
        end else if (clear_done || run_done) begin
            cnt <= '0;
        end else if (state == st_clear || state == st_compute) begin
            cnt <= cnt + CNT_W'(1);
        end else begin
            cnt <= '0;
        end
    end

endmodule

// ==== fir_cfg_regs.sv ====
`timescale 1ns/10ps
`include "fir_consts.svh"

module fir_cfg_regs (
    input  logic               axis_clk,
    input  logic               axis_rst_n,
    input  logic               awvalid,
    input  fir_pkg::fir_addr_t awaddr,
    input  logic               wvalid,
    input  fir_pkg::fir_data_t wdata,
    input  logic               arvalid,
    input  fir_pkg::fir_addr_t araddr,
    input  logic               rready,
    input  fir_pkg::ap_ctrl_t  ap_ctrl,
    input  fir_pkg::fir_ptr_t  coef_idx,
    output logic               awready,
    output logic               wready,
    output logic               arready,
    output logic               rvalid,
    output fir_pkg::fir_data_t rdata,
    output fir_pkg::fir_len_t  data_len,
    output fir_pkg::fir_len_t  tap_num,
    output fir_pkg::fir_data_t coef,
    output logic               start,
    output logic               ctrl_read
);
    import fir_pkg::*;

    fir_data_t coef_mem [`FIR_MAX_TAPS];
    logic      wr_wait;
    logic      wr_fire;
    logic      wr_ok;
    logic      rd_fire;
    logic      rd_ctrl;
    logic      ap_idle;

    function automatic logic in_coef_range(fir_addr_t addr);
        return (addr >= `FIR_ADDR_COEF_BASE) &&
               (addr < `FIR_ADDR_COEF_BASE + 4 * `FIR_MAX_TAPS);
    endfunction

    // word index inside the coefficient window
    function automatic fir_ptr_t coef_slot(fir_addr_t addr);
        fir_addr_t offs;
        offs = addr - `FIR_ADDR_COEF_BASE;
        return offs[`FIR_PTR_W+1:2];
    endfunction

    assign ap_idle   = ap_ctrl[2];
    assign wr_fire   = awvalid && awready && wvalid && wready;
    assign wr_ok     = wr_fire && ap_idle;
    assign rd_fire   = arvalid && arready;
    assign ctrl_read = rvalid && rready && rd_ctrl;
    assign coef      = coef_mem[coef_idx];

    ////////////////////
    // write channel

    // address and data are taken together, then both valids must drop
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            wr_wait <= 1'b0;
        end else begin
            awready <= awvalid && wvalid && !awready && !wr_wait;
            wready  <= awvalid && wvalid && !awready && !wr_wait;
            if (wr_fire) begin
                wr_wait <= 1'b1;
            end else if (!awvalid && !wvalid) begin
                wr_wait <= 1'b0;
            end
        end
    end

    // config only changes while idle, busy writes are acked and lost
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            data_len <= '0;
            tap_num  <= '0;
            start    <= 1'b0;
        end else begin
            start <= wr_ok && (awaddr == `FIR_ADDR_AP_CTRL) && wdata[0];
            if (wr_ok && awaddr == `FIR_ADDR_DATA_LEN) begin
                data_len <= wdata;
            end
            if (wr_ok && awaddr == `FIR_ADDR_TAP_NUM) begin
                tap_num <= wdata;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (wr_ok && in_coef_range(awaddr)) begin
            coef_mem[coef_slot(awaddr)] <= wdata;
        end
    end

    ////////////////////
    // read channel

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rd_ctrl <= 1'b0;
        end else begin
            arready <= arvalid && !arready && !rvalid;
            if (rd_fire) begin
                rvalid  <= 1'b1;
                rd_ctrl <= (araddr == `FIR_ADDR_AP_CTRL);
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (rd_fire) begin
            if (araddr == `FIR_ADDR_AP_CTRL) begin
                rdata <= fir_data_t'(ap_ctrl);
            end else if (in_coef_range(araddr)) begin
                rdata <= coef_mem[coef_slot(araddr)];
            end else begin
                rdata <= '0;
            end
        end
    end

    // read data holds until it is taken
    a_rvalid_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

// ==== fir_ctrl_fsm.sv ====
`timescale 1ns/10ps
`include "fir_consts.svh"

module fir_ctrl_fsm (
    input  logic                axis_clk,
    input  logic                axis_rst_n,
    input  logic                start,
    input  logic                clear_done,
    input  logic                run_done,
    input  logic                ctrl_read,
    input  fir_pkg::fir_len_t   data_len,
    input  logic                ss_tvalid,
    input  logic                sm_tready,
    output fir_pkg::fir_state_t state,
    output fir_pkg::ap_ctrl_t   ap_ctrl,
    output logic                ss_tready,
    output logic                sm_tvalid,
    output logic                sm_tlast,
    output logic                sample_accept
);
    import fir_pkg::*;

    fir_state_t state_nxt;
    fir_len_t   out_cnt;
    logic       out_fire;

    ////////////////////
    // run sequencing

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state <= st_clear;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_clear: begin
                if (clear_done) begin
                    state_nxt = st_idle;
                end
            end
            st_idle: begin
                if (start) begin
                    state_nxt = st_wait_in;
                end
            end
            st_wait_in: begin
                if (ss_tvalid) begin
                    state_nxt = st_compute;
                end
            end
            st_compute: begin
                if (run_done) begin
                    state_nxt = st_out;
                end
            end
            st_out: begin
                // last result goes to done, others back for the next sample
                if (sm_tready) begin
                    state_nxt = sm_tlast ? st_done : st_wait_in;
                end
            end
            st_done: begin
                if (ctrl_read) begin
                    state_nxt = st_clear;
                end
            end
            default: begin
                state_nxt = st_clear;
            end
        endcase
    end

    ////////////////////
    // stream handshakes

    assign ss_tready     = (state == st_wait_in);
    assign sm_tvalid     = (state == st_out);
    assign sample_accept = ss_tvalid && ss_tready;
    assign out_fire      = sm_tvalid && sm_tready;

    // results already delivered in this run
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            out_cnt <= '0;
        end else if (start) begin
            out_cnt <= '0;
        end else if (out_fire) begin
            out_cnt <= out_cnt + `FIR_DATA_W'(1);
        end
    end

    assign sm_tlast = sm_tvalid && (out_cnt + `FIR_DATA_W'(1) == data_len);
    assign ap_ctrl  = {state == st_idle, state == st_done, start};

    // an offered result keeps its last flag until it is taken
    a_out_held: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_tlast));

    // register block only fires start while the controller sits idle
    a_start_in_idle: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        start |-> state == st_idle);

endmodule

// ==== fir_pkg.sv ====
`include "fir_consts.svh"

package fir_pkg;

    typedef logic [`FIR_DATA_W-1:0] fir_data_t;
    typedef logic [`FIR_ADDR_W-1:0] fir_addr_t;
    typedef logic [`FIR_PTR_W-1:0]  fir_ptr_t;
    typedef logic [`FIR_DATA_W-1:0] fir_len_t;

    // {idle, done, start}
    typedef logic [2:0]             ap_ctrl_t;

    typedef enum logic [2:0] {
        st_clear,
        st_idle,
        st_wait_in,
        st_compute,
        st_out,
        st_done
    } fir_state_t;

endpackage

// ==== fir_consts.svh ====
`ifndef FIR_CONSTS_SVH
`define FIR_CONSTS_SVH

// datapath and register port widths
`define FIR_DATA_W          32
`define FIR_ADDR_W          12
`define FIR_MAX_TAPS        32
`define FIR_PTR_W           5

// register map
`define FIR_ADDR_AP_CTRL    12'h000
`define FIR_ADDR_DATA_LEN   12'h010
`define FIR_ADDR_TAP_NUM    12'h014
`define FIR_ADDR_COEF_BASE  12'h080

// cycles from tap issue until its product sits in the accumulator
`define FIR_MAC_LAT         3

`endif
